//--- Makefile
TOP := povTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert --timescale 1ns/10ps -Wno-fatal \
		-f pov.f --top-module $(TOP)

# The simulator output is shown and then searched for the pass line
run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

lint:
	verilator --lint-only --timing --timescale 1ns/10ps -Wall \
		-f pov.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- pov.f
rtl/povPkg.sv
rtl/povFrameIf.sv
rtl/spiFrameReceiver.sv
rtl/povRegisters.sv
rtl/povTop.sv
tb/povTb.sv

//--- rtl/povFrameIf.sv
`timescale 1ns/10ps

// One received viewpoint frame on its way from the SPI receiver to the register bank
interface povFrameIf;
  import povPkg::*;

  // Player position fields
  uq6p9T playerX;
  uq6p9T playerY;

  // Direction vector fields
  sq2p9T facingX;
  sq2p9T facingY;
  sq2p9T vplaneX;
  sq2p9T vplaneY;

  // Single-cycle pulse that marks the six fields as valid while it is high
  logic frameDone;

  // The SPI receiver assembles frames and drives everything
  modport sender (
    output playerX, playerY, facingX, facingY, vplaneX, vplaneY, frameDone
  );

  // The register bank always accepts, so there is no back-pressure signal
  modport receiver (
    input playerX, playerY, facingX, facingY, vplaneX, vplaneY, frameDone
  );

endinterface

//--- rtl/povPkg.sv
package povPkg;

  // Player position in UQ6.9
  // Six integer bits cover a 64 by 64 map and nine fraction bits give 1/512 of a cell
  typedef logic [14:0] uq6p9T;

  // Facing and view plane components in SQ2.9
  // The range is -2.0 up to just under 2.0, which leaves headroom above unit vectors
  typedef logic [10:0] sq2p9T;

  // Output format SQ12.12 as seen by the raycaster
  typedef logic [23:0] sq12p12T;

  // One SPI frame carries two positions followed by four direction components
  // Order on the wire is playerX, playerY, facingX, facingY, vplaneX, vplaneY, MSB first
  localparam int frameBits = 2 * $bits(uq6p9T) + 4 * $bits(sq2p9T);

  // Bit counter inside a frame that counts 0 to frameBits-1
  typedef logic [6:0] bitCountT;

  // Reset viewpoint

  // The player starts in the middle of map cell (1,1)
  // 1.5 in UQ6.9 is 1.5 * 512
  localparam uq6p9T playerInitX = 15'd768;
  localparam uq6p9T playerInitY = 15'd768;

  // Facing (0, 1.0) looks down the map in a top-down view
  localparam sq2p9T facingInitX = 11'd0;
  localparam sq2p9T facingInitY = 11'd512;

  // View plane (-0.5, 0) points left and gives a narrow but simple field of view
  // -0.5 is -256 in SQ2.9, stored as two's complement
  localparam sq2p9T vplaneInitX = 11'h700;
  localparam sq2p9T vplaneInitY = 11'd0;

endpackage

//--- rtl/povRegisters.sv
`timescale 1ns/10ps

module povRegisters (
  input logic clk,
  input logic reset,
  input logic loadIfReady,
  povFrameIf.receiver frame,
  output povPkg::sq12p12T playerX,
  output povPkg::sq12p12T playerY,
  output povPkg::sq12p12T facingX,
  output povPkg::sq12p12T facingY,
  output povPkg::sq12p12T vplaneX,
  output povPkg::sq12p12T vplaneY
);
  import povPkg::*;

  // Fraction bits before and after widening
  localparam int inFracBits = 9;
  localparam int outFracBits = 12;
  localparam int fracPad = outFracBits - inFracBits;

  // Zero bits above a position and sign bits above a direction component
  localparam int posHiPad = $bits(sq12p12T) - $bits(uq6p9T) - fracPad;
  localparam int dirHiPad = $bits(sq12p12T) - $bits(sq2p9T) - fracPad;

  // Ready buffer, holding the newest complete frame
  uq6p9T bufPlayerX;
  uq6p9T bufPlayerY;
  sq2p9T bufFacingX;
  sq2p9T bufFacingY;
  sq2p9T bufVplaneX;
  sq2p9T bufVplaneY;

  // Set once any frame has arrived and never cleared by a load
  logic ready;

  // Live viewpoint seen by the renderer
  uq6p9T livePlayerX;
  uq6p9T livePlayerY;
  sq2p9T liveFacingX;
  sq2p9T liveFacingY;
  sq2p9T liveVplaneX;
  sq2p9T liveVplaneY;

  // Position is unsigned so it only needs zero padding on both sides
  function automatic sq12p12T widenPos(input uq6p9T value);
    return {{posHiPad{1'b0}}, value, {fracPad{1'b0}}};
  endfunction

  // Direction components keep their sign by repeating the top bit
  function automatic sq12p12T widenDir(input sq2p9T value);
    return {{dirHiPad{value[$bits(sq2p9T)-1]}}, value, {fracPad{1'b0}}};
  endfunction

  // Capture each completed frame
  always_ff @(posedge clk) begin
    if (frame.frameDone) begin
      bufPlayerX <= frame.playerX;
      bufPlayerY <= frame.playerY;
      bufFacingX <= frame.facingX;
      bufFacingY <= frame.facingY;
      bufVplaneX <= frame.vplaneX;
      bufVplaneY <= frame.vplaneY;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ready <= 1'b0;
    end else if (frame.frameDone) begin
      ready <= 1'b1;
    end
  end

  // Go live on request
  // A frame landing in the same cycle is not seen yet and the old buffer is copied
  always_ff @(posedge clk) begin
    if (reset) begin
      livePlayerX <= playerInitX;
      livePlayerY <= playerInitY;
      liveFacingX <= facingInitX;
      liveFacingY <= facingInitY;
      liveVplaneX <= vplaneInitX;
      liveVplaneY <= vplaneInitY;
    end else if (loadIfReady && ready) begin
      livePlayerX <= bufPlayerX;
      livePlayerY <= bufPlayerY;
      liveFacingX <= bufFacingX;
      liveFacingY <= bufFacingY;
      liveVplaneX <= bufVplaneX;
      liveVplaneY <= bufVplaneY;
    end
  end

  // Present the live registers as SQ12.12
  assign playerX = widenPos(livePlayerX);
  assign playerY = widenPos(livePlayerY);
  assign facingX = widenDir(liveFacingX);
  assign facingY = widenDir(liveFacingY);
  assign vplaneX = widenDir(liveVplaneX);
  assign vplaneY = widenDir(liveVplaneY);

  // The renderer only ever sees a new viewpoint on a granted load or out of reset
  assert property (@(posedge clk) disable iff (reset)
    !$past(reset) && !$past(loadIfReady && ready) |->
      $stable({livePlayerX, livePlayerY, liveFacingX, liveFacingY,
               liveVplaneX, liveVplaneY}));

endmodule

//--- rtl/povTop.sv
`timescale 1ns/10ps

module povTop #(
  parameter int syncStages = 2
) (
  input logic clk,
  input logic reset,
  // SPI receive pins from the host
  input logic sclk,
  input logic ssN,
  input logic mosi,
  // Vertical blank strobe from the render side
  input logic loadIfReady,
  // Live viewpoint in SQ12.12
  output povPkg::sq12p12T playerX,
  output povPkg::sq12p12T playerY,
  output povPkg::sq12p12T facingX,
  output povPkg::sq12p12T facingY,
  output povPkg::sq12p12T vplaneX,
  output povPkg::sq12p12T vplaneY
);

  // Completed frames travel from the receiver to the register bank here
  povFrameIf i_frameIf ();

  // Turns the SPI stream into one strobed frame every 74 bits
  spiFrameReceiver #(
    .syncStages(syncStages)
  ) i_receiver (
    .clk(clk),
    .reset(reset),
    .sclk(sclk),
    .ssN(ssN),
    .mosi(mosi),
    .frame(i_frameIf.sender)
  );

  // Double buffer where the newest frame waits until the renderer asks for it
  povRegisters i_registers (
    .clk(clk),
    .reset(reset),
    .loadIfReady(loadIfReady),
    .frame(i_frameIf.receiver),
    .playerX(playerX),
    .playerY(playerY),
    .facingX(facingX),
    .facingY(facingY),
    .vplaneX(vplaneX),
    .vplaneY(vplaneY)
  );

endmodule

//--- rtl/spiFrameReceiver.sv
`timescale 1ns/10ps

module spiFrameReceiver #(
  parameter int syncStages = 2
) (
  input logic clk,
  input logic reset,
  input logic sclk,
  input logic ssN,
  input logic mosi,
  povFrameIf.sender frame
);
  import povPkg::*;

  // Counter value while the final bit of a frame is being taken
  localparam bitCountT lastBit = bitCountT'(frameBits - 1);

  // SCLK carries one stage more than the others so that its last two stages show an edge
  logic [syncStages:0] sclkSync;
  logic [syncStages-1:0] ssNSync;
  logic [syncStages-1:0] mosiSync;

  // Synchronized views of the SPI pins
  logic sclkRise;
  logic ssActive;
  logic mosiBit;

  // Frame assembly state
  bitCountT bitCount;
  logic [frameBits-1:0] shiftReg;

  // High for one cycle once the shift register holds a complete frame
  logic frameFull;

  // Input synchronizers
  // The select line resets to inactive, so any SCLK activity before it settles is ignored
  always_ff @(posedge clk) begin
    if (reset) begin
      sclkSync <= '0;
      ssNSync <= '1;
    end else begin
      sclkSync <= {sclkSync[syncStages-1:0], sclk};
      ssNSync <= {ssNSync[syncStages-2:0], ssN};
    end
  end

  // MOSI synchronizer
  always_ff @(posedge clk) begin
    mosiSync <= {mosiSync[syncStages-2:0], mosi};
  end

  // A rising edge shows as a one in the newer stage and a zero in the older one
  assign sclkRise = sclkSync[syncStages-1] & ~sclkSync[syncStages];
  assign ssActive = ~ssNSync[syncStages-1];

  // MOSI comes out of a chain as deep as the SCLK stage that flags the edge
  // so the bit seen here is the level at the moment SCLK rose
  assign mosiBit = mosiSync[syncStages-1];

  // Bit counter
  // Dropping the select clears the count and throws away any partial frame
  // The count wraps after the last bit so frames may follow back to back
  always_ff @(posedge clk) begin
    if (reset) begin
      bitCount <= '0;
      frameFull <= 1'b0;
    end else if (!ssActive) begin
      bitCount <= '0;
      frameFull <= 1'b0;
    end else if (sclkRise) begin
      if (bitCount == lastBit) begin
        bitCount <= '0;
      end else begin
        bitCount <= bitCount + 1'b1;
      end
      frameFull <= (bitCount == lastBit);
    end else begin
      frameFull <= 1'b0;
    end
  end

  // Shift register that fills MSB first
  // The oldest bit ends up at the top as the first bit of playerX
  always_ff @(posedge clk) begin
    if (ssActive && sclkRise) begin
      shiftReg <= {shiftReg[frameBits-2:0], mosiBit};
    end
  end

  // Completion strobe
  // It is held back one cycle so the fields below are registered alongside it
  always_ff @(posedge clk) begin
    if (reset) begin
      frame.frameDone <= 1'b0;
    end else begin
      frame.frameDone <= frameFull;
    end
  end

  // Slice the finished frame into its six fields
  // These stay put until the next frame completes, even while new bits shift in
  always_ff @(posedge clk) begin
    if (frameFull) begin
      {frame.playerX, frame.playerY,
       frame.facingX, frame.facingY,
       frame.vplaneX, frame.vplaneY} <= shiftReg;
    end
  end

  // A completed frame is only ever flagged while the select is still active
  assert property (@(posedge clk) disable iff (reset)
    frame.frameDone |-> ssActive);

  // The counter never runs past the last bit of a frame
  assert property (@(posedge clk) disable iff (reset)
    bitCount <= lastBit);

endmodule

//--- tb/povTb.sv
`timescale 1ns/10ps

module povTb;
  import povPkg::*;

  // A frame has landed in the ready buffer well within this many clocks
  localparam int settleCycles = 20;
  localparam int watchdogCycles = 50000;
  localparam int maxLines = 1000;
  localparam logic [31:0] lfsrSeed = 32'h2e184046;
  // Taps 32, 22, 2 and 1 give a maximal length sequence
  localparam logic [31:0] lfsrTaps = 32'h80200003;

  logic clk;
  logic reset;
  logic sclk;
  logic ssN;
  logic mosi;
  logic loadIfReady;

  sq12p12T playerX;
  sq12p12T playerY;
  sq12p12T facingX;
  sq12p12T facingY;
  sq12p12T vplaneX;
  sq12p12T vplaneY;

  // Random state for the SPI half period
  logic [31:0] lfsrState;
  int checkCount;

  povTop #(
    .syncStages(2)
  ) i_dut (
    .clk(clk),
    .reset(reset),
    .sclk(sclk),
    .ssN(ssN),
    .mosi(mosi),
    .loadIfReady(loadIfReady),
    .playerX(playerX),
    .playerY(playerY),
    .facingX(facingX),
    .facingY(facingY),
    .vplaneX(vplaneX),
    .vplaneY(vplaneY)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // One step of a right-shifting Galois LFSR
  function automatic logic [31:0] galoisStep(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ lfsrTaps;
    end
    return state >> 1;
  endfunction

  // Takes count bits from the LFSR, stepping it once per bit
  task automatic drawBits(input int count, output int value);
    value = 0;
    for (int i = 0; i < count; i++) begin
      value = (value << 1) | int'(lfsrState[0]);
      lfsrState = galoisStep(lfsrState);
    end
  endtask

  task automatic waitCycles(input int count);
    for (int i = 0; i < count; i++) begin
      @(posedge clk);
    end
  endtask

  task automatic stopOnError(input string message);
    $display("%s", message);
    $display("STATUS: FAIL");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic compareValue(input string name, input sq12p12T actual,
                              input sq12p12T expected);
    checkCount++;
    if (actual !== expected) begin
      stopOnError($sformatf("Mismatch at %0t: %s is %06h, expected %06h",
                            $time, name, actual, expected));
    end
  endtask

  // Outputs are compared at the falling edge, half a clock away from any update
  task automatic checkOutputs(input sq12p12T expPlayerX, input sq12p12T expPlayerY,
                              input sq12p12T expFacingX, input sq12p12T expFacingY,
                              input sq12p12T expVplaneX, input sq12p12T expVplaneY);
    @(negedge clk);
    compareValue("playerX", playerX, expPlayerX);
    compareValue("playerY", playerY, expPlayerY);
    compareValue("facingX", facingX, expFacingX);
    compareValue("facingY", facingY, expFacingY);
    compareValue("vplaneX", vplaneX, expVplaneX);
    compareValue("vplaneY", vplaneY, expVplaneY);
  endtask

  // Sends one frame MSB first, SPI mode 0, with a random half period of 2 to 5 clocks
  // A nonzero abortAfter raises SS after that many bits, and holdSelect leaves SS low
  task automatic sendFrame(input uq6p9T pX, input uq6p9T pY,
                           input sq2p9T fX, input sq2p9T fY,
                           input sq2p9T vX, input sq2p9T vY,
                           input int abortAfter, input int holdSelect);
    logic [frameBits-1:0] bits;
    int bitTotal;
    int half;
    bits = {pX, pY, fX, fY, vX, vY};
    bitTotal = frameBits;
    if (abortAfter > 0 && abortAfter < frameBits) begin
      bitTotal = abortAfter;
    end
    @(posedge clk);
    ssN <= 1'b0;
    for (int i = 0; i < bitTotal; i++) begin
      drawBits(2, half);
      half = half + 2;
      // MOSI changes while SCLK is low and holds across the rising edge
      mosi <= bits[frameBits-1-i];
      waitCycles(half);
      sclk <= 1'b1;
      waitCycles(half);
      sclk <= 1'b0;
    end
    waitCycles(half);
    if (holdSelect == 0) begin
      ssN <= 1'b1;
    end
    mosi <= 1'b0;
    waitCycles(settleCycles);
  endtask

  // loadIfReady is high for exactly one rising edge
  task automatic pulseLoad();
    @(posedge clk);
    loadIfReady <= 1'b1;
    @(posedge clk);
    loadIfReady <= 1'b0;
    waitCycles(2);
  endtask

  initial begin
    int fd;
    int lineNo;
    int fields;
    string line;
    byte kind;
    logic [31:0] field [8];
    sclk = 1'b0;
    ssN = 1'b1;
    mosi = 1'b0;
    loadIfReady = 1'b0;
    reset = 1'b1;
    lfsrState = lfsrSeed;
    checkCount = 0;
    fd = $fopen("tb/povTestdata.txt", "r");
    if (fd == 0) begin
      stopOnError("Could not open the data file tb/povTestdata.txt");
    end
    waitCycles(4);
    reset <= 1'b0;
    waitCycles(2);
    lineNo = 0;
    while (!$feof(fd) && lineNo < maxLines) begin
      line = "";
      void'($fgets(line, fd));
      lineNo++;
      if (line.len() == 0) begin
        continue;
      end
      kind = line.getc(0);
      if (kind == "S") begin
        fields = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h %h %d %d",
                         field[0], field[1], field[2], field[3],
                         field[4], field[5], field[6], field[7]);
        if (fields != 8) begin
          stopOnError($sformatf("Line %0d of the data file is not a valid send step",
                                lineNo));
        end
        sendFrame(uq6p9T'(field[0]), uq6p9T'(field[1]),
                  sq2p9T'(field[2]), sq2p9T'(field[3]),
                  sq2p9T'(field[4]), sq2p9T'(field[5]),
                  int'(field[6]), int'(field[7]));
      end else if (kind == "L") begin
        pulseLoad();
      end else if (kind == "C") begin
        fields = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h %h",
                         field[0], field[1], field[2], field[3], field[4], field[5]);
        if (fields != 6) begin
          stopOnError($sformatf("Line %0d of the data file is not a valid check step",
                                lineNo));
        end
        checkOutputs(sq12p12T'(field[0]), sq12p12T'(field[1]), sq12p12T'(field[2]),
                     sq12p12T'(field[3]), sq12p12T'(field[4]), sq12p12T'(field[5]));
      end else if (kind != "#" && kind != 8'h0a && kind != 8'h0d) begin
        stopOnError($sformatf("Line %0d of the data file has an unknown step kind",
                              lineNo));
      end
    end
    if (!$feof(fd)) begin
      stopOnError("The data file has more lines than the testbench accepts");
    end
    $fclose(fd);
    if (checkCount > 0) begin
      $display("STATUS: PASS");
    end else begin
      stopOnError("The data file held no check steps");
    end
    $finish;
  end

  // Watchdog in case the DUT or a step stalls the run
  initial begin
    waitCycles(watchdogCycles);
    stopOnError("The simulation ran past its cycle limit without finishing");
  end

endmodule

//--- tb/povTestdata.txt
# S playerX playerY facingX facingY vplaneX vplaneY abortAfter hold : send a frame (hex fields)
#   abortAfter and hold are decimal, abortAfter 0 sends all 74 bits, hold 1 keeps SS low
# L : pulse loadIfReady, C playerX playerY facingX facingY vplaneX vplaneY : expected SQ12.12

# Reset viewpoint (1.5, 1.5), facing (0, 1.0), plane (-0.5, 0)
C 001800 001800 000000 001000 fff800 000000

# A load before any frame has arrived changes nothing
L
C 001800 001800 000000 001000 fff800 000000

# Frame A without a load leaves the outputs alone
S 1480 4380 16a 696 0b5 74b 0 0
C 001800 001800 000000 001000 fff800 000000

# The load brings frame A live with sign extension on the negative components
L
C 00a400 021c00 000b50 fff4b0 0005a8 fffa58

# Frame B cut off after 30 bits is discarded
S 7fff 0001 400 3ff 123 456 30 0
L
C 00a400 021c00 000b50 fff4b0 0005a8 fffa58

# Frame C at the range limits is still received cleanly
S 7fff 0000 400 3ff 000 200 0 0
C 00a400 021c00 000b50 fff4b0 0005a8 fffa58
L
C 03fff8 000000 ffe000 001ff8 000000 001000

# Frames D and E back to back under one select, the load gives E
S 0200 0400 200 000 000 100 0 1
S 5555 2aaa 555 2aa 7ff 001 0 0
L
C 02aaa8 015550 ffeaa8 001550 fffff8 000008

# Repeated loads reload the same buffer
L
C 02aaa8 015550 ffeaa8 001550 fffff8 000008
L
C 02aaa8 015550 ffeaa8 001550 fffff8 000008

# Frame F waits in the buffer until the next load
S 0c00 1e00 600 000 000 133 0 0
C 02aaa8 015550 ffeaa8 001550 fffff8 000008
L
C 006000 00f000 fff000 000000 000000 000998

# Frame G cut off one bit short is discarded
S 0001 0002 003 004 005 006 73 0
L
C 006000 00f000 fff000 000000 000000 000998

# Frame H after the abort arrives intact
S 3c00 0a00 1ff 601 0ff 700 0 0
L
C 01e000 005000 000ff8 fff008 0007f8 fff800
